/* run_sim.sh */
#!/usr/bin/env bash
# compile the video mixer testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
    -f video_mixer_top.f \
    --top-module video_mixer_tb \
    -o video_mixer_sim

sim_out=$(./obj_dir/video_mixer_sim)
echo "$sim_out"

if grep -qF -- '** PASS **' <<< "$sim_out"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi

/* source/color_lookup.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// palette colour lookup
// 256 x 16 ARGB RAM with a host write port and
// one registered read per pixel clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module color_lookup (
    input  logic                  clk,
    // host write side
    input  video_pkg::pal_wr_t    pal_wr_i,
    input  logic                  wr_i,
    // pixel read side
    input  video_pkg::pal_index_t index_i,
    output video_pkg::argb_t      argb_o
);

    // palette storage
    // holds whatever the host last wrote
    video_pkg::argb_t pal_mem [video_pkg::pal_depth];

    // write port
    // a strobe held one cycle stores the word at the next edge
    always_ff @(posedge clk) begin
        if (wr_i) begin
            pal_mem[pal_wr_i.addr] <= pal_wr_i.data;
        end
    end

    // read port
    // reads every cycle whatever the write port is doing
    // same-entry write and read returns the old word (read first)
    always_ff @(posedge clk) begin
        argb_o <= pal_mem[index_i];
    end

    // argb_o lags index_i by exactly one pixel clock
    // the blend stage relies on this to line up its de

endmodule

/* source/video_blend.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video blend stage
// mixes the playfield A and B palette words into one
// 12-bit colour and delays the timing levels to match
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_blend (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // raster timing, same cycle as the palette index
    input  video_pkg::vid_timing_t timing_i,
    // palette words, one cycle after the index
    input  video_pkg::argb_t       color_a_i,
    input  video_pkg::argb_t       color_b_i,
    // blended colour and aligned timing
    output video_pkg::rgb_t        rgb_o,
    output video_pkg::vid_timing_t timing_o
);

    // A is the bottom playfield and B is drawn over it
    //
    //  A     B
    //  0xxx  00xx  A only
    //  0xxx  01xx  75% A + 25% B
    //  0xxx  10xx  50% A + 50% B
    //  0xxx  11xx  B only
    //  1xxx  00xx  A + B       clamp at F
    //  1xxx  01xx  A - B       clamp at 0
    //  1xxx  10xx  A + sB      clamp by sign of B
    //  1xxx  11xx  A + 2*sB    clamp by sign of B
    //
    // remaining alpha bits are ignored

    // timing delayed once to line up with the palette words
    video_pkg::vid_timing_t timing_1;

    // mode select for the current pixel
    logic [2:0] blend_mode;

    // one 4-bit channel of the blend
    // r, g and b each go through this on their own
    function automatic logic [3:0] blend_chan(
        input logic [2:0] mode,
        input logic [3:0] a,
        input logic [3:0] b
    );
        logic [4:0] sum_ab;
        logic [4:0] diff_ab;
        logic [5:0] mix_25;
        logic [4:0] sum_sb;
        logic [4:0] sum_ab_x2;
        logic [3:0] res;

        // 5-bit add with bit 4 as the carry
        sum_ab    = {1'b0, a} + {1'b0, b};
        // 5-bit subtract with bit 4 as the borrow
        diff_ab   = {1'b0, a} - {1'b0, b};
        // top 4 bits of A + 2A + B give (3A + B) / 4
        mix_25    = {2'b00, a} + {1'b0, a, 1'b0} + {2'b00, b};
        // signed b sign-extended so bit 4 flags overflow in either direction
        sum_sb    = {1'b0, a} + {b[3], b};
        // signed b doubled before the add
        sum_ab_x2 = {1'b0, a} + {b, 1'b0};

        case (mode)
            video_pkg::blend_a_only: begin
                res = a;
            end
            video_pkg::blend_mix_25: begin
                res = mix_25[5:2];
            end
            video_pkg::blend_mix_50: begin
                // drop the low bit of the sum to truncate
                res = sum_ab[4:1];
            end
            video_pkg::blend_b_only: begin
                res = b;
            end
            video_pkg::blend_add: begin
                // saturate on carry
                res = sum_ab[4] ? 4'hf : sum_ab[3:0];
            end
            video_pkg::blend_sub: begin
                // floor on borrow
                res = diff_ab[4] ? 4'h0 : diff_ab[3:0];
            end
            video_pkg::blend_delta: begin
                // sign of b picks the clamp end
                res = sum_sb[4] ? (b[3] ? 4'h0 : 4'hf) : sum_sb[3:0];
            end
            video_pkg::blend_dx2: begin
                // doubled delta uses the same clamp rule
                res = sum_ab_x2[4] ? (b[3] ? 4'h0 : 4'hf) : sum_ab_x2[3:0];
            end
        endcase
        return res;
    endfunction

    // A's top alpha bit picks alpha mix or arithmetic
    // B's top two alpha bits pick the operation
    assign blend_mode = {color_a_i.a[3], color_b_i.a[3:2]};

    // timing pipeline
    // first stage qualifies the palette words and the second drives the output
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            timing_1 <= '0;
            timing_o <= '0;
        end else begin
            timing_1 <= timing_i;
            timing_o <= timing_1;
        end
    end

    // colour register
    // black whenever the delayed de is low
    always_ff @(posedge clk) begin
        if (timing_1.de) begin
            rgb_o.r <= blend_chan(blend_mode, color_a_i.rgb.r, color_b_i.rgb.r);
            rgb_o.g <= blend_chan(blend_mode, color_a_i.rgb.g, color_b_i.rgb.g);
            rgb_o.b <= blend_chan(blend_mode, color_a_i.rgb.b, color_b_i.rgb.b);
        end else begin
            rgb_o <= '0;
        end
    end

endmodule

/* source/video_mixer_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-playfield video mixer
// palette lookup for A and B feeding the blend stage
// two clocks from index to colour
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_mixer_top (
    input  logic                   clk,
    input  logic                   rst_n_i,
    // host palette writes
    input  video_pkg::pal_wr_t     pal_wr_i,
    input  logic                   pal_a_wr_i,
    input  logic                   pal_b_wr_i,
    // raster side, one pixel per clock
    input  video_pkg::pal_index_t  index_a_i,
    input  video_pkg::pal_index_t  index_b_i,
    input  video_pkg::vid_timing_t timing_i,
    // video out
    output video_pkg::rgb_t        rgb_o,
    output video_pkg::vid_timing_t timing_o
);

    // palette words, one clock after the index
    video_pkg::argb_t argb_a;
    video_pkg::argb_t argb_b;

    // playfield A palette
    color_lookup pf_a_lookup (
        .clk      (clk),
        .pal_wr_i (pal_wr_i),
        .wr_i     (pal_a_wr_i),
        .index_i  (index_a_i),
        .argb_o   (argb_a)
    );

    // playfield B palette
    // shares the write bus, own strobe
    color_lookup pf_b_lookup (
        .clk      (clk),
        .pal_wr_i (pal_wr_i),
        .wr_i     (pal_b_wr_i),
        .index_i  (index_b_i),
        .argb_o   (argb_b)
    );

    // blend takes the raw timing and delays it internally
    video_blend video_blend_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .timing_i  (timing_i),
        .color_a_i (argb_a),
        .color_b_i (argb_b),
        .rgb_o     (rgb_o),
        .timing_o  (timing_o)
    );

endmodule

/* source/video_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video mixer package
// palette, colour and timing types shared by the
// palette lookups and the blend stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package video_pkg;

    // palette index width, 256 entries per playfield
    localparam int pal_addr_w = 8;
    localparam int pal_depth  = 1 << pal_addr_w;

    // blend mode codes {A alpha[3], B alpha[3:2]}
    // alpha mixes when A's top bit is clear
    localparam logic [2:0] blend_a_only = 3'b0_00;
    localparam logic [2:0] blend_mix_25 = 3'b0_01;
    localparam logic [2:0] blend_mix_50 = 3'b0_10;
    localparam logic [2:0] blend_b_only = 3'b0_11;
    // clamped arithmetic when A's top bit is set
    localparam logic [2:0] blend_add    = 3'b1_00;
    localparam logic [2:0] blend_sub    = 3'b1_01;
    localparam logic [2:0] blend_delta  = 3'b1_10;
    localparam logic [2:0] blend_dx2    = 3'b1_11;

    typedef logic [pal_addr_w-1:0] pal_index_t;

    // 12-bit colour, 4 bits per channel
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // palette word, alpha/mode nibble on top
    typedef struct packed {
        logic [3:0] a;
        rgb_t       rgb;
    } argb_t;

    // host write bus, shared by both palettes
    typedef struct packed {
        pal_index_t addr;
        argb_t      data;
    } pal_wr_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
    } vid_timing_t;

endpackage

/* testbench/video_mixer_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video mixer testbench
// fills both palettes, runs table and random pixels
// through the mixer and checks colour and timing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module video_mixer_tb;

    // one pixel case with the values expected two clocks after it goes in
    typedef struct packed {
        video_pkg::pal_index_t  idx_a;
        video_pkg::pal_index_t  idx_b;
        video_pkg::vid_timing_t timing;
        video_pkg::rgb_t        rgb;
    } pix_case_t;

    logic                   clk = 1'b0;
    logic                   rst_n_i;
    video_pkg::pal_wr_t     pal_wr_i;
    logic                   pal_a_wr_i;
    logic                   pal_b_wr_i;
    video_pkg::pal_index_t  index_a_i;
    video_pkg::pal_index_t  index_b_i;
    video_pkg::vid_timing_t timing_i;
    video_pkg::rgb_t        rgb_o;
    video_pkg::vid_timing_t timing_o;

    // model copies of both palettes
    video_pkg::argb_t pal_a [256];
    video_pkg::argb_t pal_b [256];

    // rows in flight
    // pipe1 is the one due at the next check
    pix_case_t pipe0;
    pix_case_t pipe1;
    bit        v0 = 1'b0;
    bit        v1 = 1'b0;

    int test_errs  = 0;
    int pass_tests = 0;
    int fail_tests = 0;

    // fixed cases with hand-worked expected colours
    // A1 = 0_8C3, A2 = 8_C4F, A3 = 8_394, A6 = 8_2D0, B1..B4 = {0,4,8,C}_5A7
    pix_case_t fixed_tab [21] = '{
        // alpha mixes: A only, 75/25, 50/50, B only
        {8'd1, 8'd1, 3'b001, 12'h8c3},
        {8'd1, 8'd2, 3'b001, 12'h7b4},
        {8'd1, 8'd3, 3'b001, 12'h6b5},
        {8'd1, 8'd4, 3'b001, 12'h5a7},
        // add, sub, delta, doubled delta with carry and no carry
        {8'd2, 8'd1, 3'b001, 12'hfef},
        {8'd3, 8'd1, 3'b001, 12'h8fb},
        {8'd2, 8'd2, 3'b001, 12'h708},
        {8'd3, 8'd2, 3'b001, 12'h000},
        {8'd6, 8'd2, 3'b001, 12'h030},
        {8'd2, 8'd3, 3'b001, 12'hf0f},
        {8'd3, 8'd3, 3'b001, 12'h83b},
        {8'd2, 8'd4, 3'b001, 12'hf0f},
        {8'd3, 8'd4, 3'b001, 12'hd0f},
        {8'd6, 8'd4, 3'b001, 12'hc1e},
        // timing patterns, black whenever de is low
        {8'd1, 8'd4, 3'b101, 12'h5a7},
        {8'd2, 8'd1, 3'b110, 12'h000},
        {8'd3, 8'd3, 3'b011, 12'h83b},
        {8'd2, 8'd2, 3'b100, 12'h000},
        {8'd1, 8'd1, 3'b111, 12'h8c3},
        {8'd3, 8'd4, 3'b010, 12'h000},
        {8'd1, 8'd2, 3'b000, 12'h000}
    };

    video_mixer_top video_mixer_top_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pal_wr_i   (pal_wr_i),
        .pal_a_wr_i (pal_a_wr_i),
        .pal_b_wr_i (pal_b_wr_i),
        .index_a_i  (index_a_i),
        .index_b_i  (index_b_i),
        .timing_i   (timing_i),
        .rgb_o      (rgb_o),
        .timing_o   (timing_o)
    );

    always #5 clk = ~clk;

    // reference for one channel worked from the blend rules
    function automatic logic [3:0] blend_ref(
        input logic [2:0] mode,
        input logic [3:0] a,
        input logic [3:0] b
    );
        int ai;
        int bi;
        int sbi;
        int s;
        ai  = int'(a);
        bi  = int'(b);
        // b as a signed nibble for the two delta modes
        sbi = b[3] ? bi - 16 : bi;
        case (mode)
            3'd0: s = ai;
            3'd1: s = (3 * ai + bi) / 4;
            3'd2: s = (ai + bi) / 2;
            3'd3: s = bi;
            3'd4: s = (ai + bi > 15) ? 15 : ai + bi;
            3'd5: s = (ai < bi) ? 0 : ai - bi;
            3'd6: s = ai + sbi;
            default: s = ai + 2 * sbi;
        endcase
        // signed results saturate at both ends of the nibble
        if (s > 15) begin
            s = 15;
        end else if (s < 0) begin
            s = 0;
        end
        return s[3:0];
    endfunction

    // expected colour for a pair of palette words
    function automatic video_pkg::rgb_t predict_rgb(
        input video_pkg::argb_t a,
        input video_pkg::argb_t b,
        input logic             de
    );
        logic [2:0]      mode;
        video_pkg::rgb_t res;
        mode = {a.a[3], b.a[3:2]};
        res  = '0;
        if (de) begin
            res.r = blend_ref(mode, a.rgb.r, b.rgb.r);
            res.g = blend_ref(mode, a.rgb.g, b.rgb.g);
            res.b = blend_ref(mode, a.rgb.b, b.rgb.b);
        end
        return res;
    endfunction

    task automatic check_outputs(input pix_case_t row);
        assert (rgb_o == row.rgb) else begin
            $display("ERR rgb_o expected %h got %h (index a %h b %h)",
                     row.rgb, rgb_o, row.idx_a, row.idx_b);
            test_errs++;
        end
        assert (timing_o == row.timing) else begin
            $display("ERR timing_o expected %h got %h", row.timing, timing_o);
            test_errs++;
        end
    endtask

    // one pixel per clock
    // each is checked two clocks after it goes in
    task automatic apply_pixel(input pix_case_t row, input bit chk);
        @(posedge clk);
        #1;
        if (v1) check_outputs(pipe1);
        pipe1      = pipe0;
        v1         = v0;
        pipe0      = row;
        v0         = chk;
        pal_a_wr_i = 1'b0;
        pal_b_wr_i = 1'b0;
        index_a_i  = row.idx_a;
        index_b_i  = row.idx_b;
        timing_i   = row.timing;
    endtask

    // two idle pixels drain whatever is still in flight
    task automatic flush_pipe();
        apply_pixel('0, 1'b0);
        apply_pixel('0, 1'b0);
    endtask

    task automatic write_entry(
        input bit                    to_b,
        input video_pkg::pal_index_t addr,
        input video_pkg::argb_t      data
    );
        @(posedge clk);
        #1;
        pal_wr_i.addr = addr;
        pal_wr_i.data = data;
        pal_a_wr_i    = !to_b;
        pal_b_wr_i    = to_b;
    endtask

    // count clocks from a single de pulse until it shows on timing_o
    task automatic measure_latency();
        int cycles;
        @(posedge clk);
        #1;
        timing_i = 3'b001;
        @(posedge clk);
        #1;
        timing_i = '0;
        cycles   = 1;
        while (!timing_o.de && cycles < 10) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!timing_o.de) begin
            $display("timeout: de never reached timing_o within 10 clocks");
            test_errs++;
        end else begin
            assert (cycles == 2) else begin
                $display("ERR timing_o.de latency expected %h got %h", 2, cycles);
                test_errs++;
            end
        end
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %s ok", name);
            pass_tests++;
        end else begin
            $display("test %s failed with %0d errors", name, test_errs);
            fail_tests++;
        end
        test_errs = 0;
    endtask

    task automatic run_rows(input int first, input int last, input string name);
        for (int i = first; i <= last; i++) begin
            apply_pixel(fixed_tab[i], 1'b1);
        end
        flush_pipe();
        end_test(name);
    endtask

    initial begin
        pix_case_t   row;
        logic [31:0] rnd;

        rst_n_i    = 1'b0;
        pal_wr_i   = '0;
        pal_a_wr_i = 1'b0;
        pal_b_wr_i = 1'b0;
        index_a_i  = 8'h11;
        index_b_i  = 8'h22;
        timing_i   = 3'b111;
        void'($urandom(32'h474e));

        // reset held for 4 clocks with all timing levels high
        for (int c = 1; c <= 5; c++) begin
            @(posedge clk);
            #1;
            if (c >= 2) begin
                assert (timing_o == '0) else begin
                    $display("ERR timing_o expected %h got %h on reset clock %0d",
                             3'h0, timing_o, c);
                    test_errs++;
                end
                assert (rgb_o == '0) else begin
                    $display("ERR rgb_o expected %h got %h on reset clock %0d",
                             12'h000, rgb_o, c);
                    test_errs++;
                end
            end
            if (c == 4) rst_n_i = 1'b1;
        end
        end_test("reset");

        // random palettes with the fixed entries on top
        for (int i = 0; i < 256; i++) begin
            rnd      = $urandom();
            pal_a[i] = rnd[15:0];
            pal_b[i] = rnd[31:16];
        end
        pal_a[1] = 16'h08c3;
        pal_a[2] = 16'h8c4f;
        pal_a[3] = 16'h8394;
        pal_a[5] = 16'h0123;
        pal_a[6] = 16'h82d0;
        pal_b[0] = 16'h03c1;
        pal_b[1] = 16'h05a7;
        pal_b[2] = 16'h45a7;
        pal_b[3] = 16'h85a7;
        pal_b[4] = 16'hc5a7;
        timing_i = '0;
        for (int i = 0; i < 256; i++) begin
            write_entry(1'b0, i[7:0], pal_a[i]);
            write_entry(1'b1, i[7:0], pal_b[i]);
        end

        run_rows(0, 3, "alpha mix");
        run_rows(4, 13, "arithmetic clamp");
        run_rows(14, 20, "timing alignment");
        measure_latency();
        end_test("latency");

        // back to back pixels with random indices and timing
        for (int n = 0; n < 200; n++) begin
            rnd        = $urandom();
            row.idx_a  = rnd[7:0];
            row.idx_b  = rnd[15:8];
            row.timing = rnd[18:16];
            row.rgb    = predict_rgb(pal_a[row.idx_a], pal_b[row.idx_b], row.timing.de);
            apply_pixel(row, 1'b1);
        end
        flush_pipe();
        end_test("random sweep");

        // A5 rewritten while it is read
        // the old word comes out first and the new one next
        apply_pixel({8'd5, 8'd0, 3'b001, 12'h123}, 1'b1);
        pal_wr_i.addr = 8'd5;
        pal_wr_i.data = 16'h09e6;
        pal_a_wr_i    = 1'b1;
        pal_a[5]      = 16'h09e6;
        apply_pixel({8'd5, 8'd0, 3'b001, 12'h9e6}, 1'b1);
        flush_pipe();
        end_test("write during display");

        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* video_mixer_top.f */
source/video_pkg.sv
source/color_lookup.sv
source/video_blend.sv
source/video_mixer_top.sv
testbench/video_mixer_tb.sv
